// ==== source/pcie_cfg_macros.svh ====
// Build constants for the configuration readback engine.
// Include in any RTL file that needs function count, register address,
// Device Control field positions or the scan interval.

`ifndef PCIE_CFG_MACROS_SVH
`define PCIE_CFG_MACROS_SVH

// Physical functions walked by each scan
`define PCIE_PF_COUNT 2

// PCIe capability location in configuration space (bytes)
`define PCIE_CAP_OFFSET 12'h0C0

// Device Control sits 8 bytes into the capability, addressed in dwords
`define PCIE_DEV_CTRL_DWORD ((`PCIE_CAP_OFFSET + 8) / 4)

// Clocks between scan starts
`define CFG_REFRESH_CYCLES 64

// Device Control field LSBs, each 3-bit field spans LSB+2..LSB
`define DEV_CTRL_MPS_LSB 5
`define DEV_CTRL_EXT_TAG_BIT 8
`define DEV_CTRL_MRRS_LSB 12

`endif

// ==== source/pcie_cfg_pkg.sv ====
// Shared types of the configuration readback engine.
// Modules import it inside their body, or use scoped names in port lists.

package pcie_cfg_pkg;

    // Dword address on the configuration management port
    typedef logic [9:0] cfg_addr_t;

    // Function number on the configuration management port
    typedef logic [7:0] func_num_t;

    // Fields of interest from Device Control
    typedef struct packed {
        logic       ext_tag;
        logic [2:0] mrrs;
        logic [2:0] mps;
    } dev_ctrl_t;

    // Scan sequencer states
    typedef enum logic [1:0] {
        IDLE,
        READ,
        NEXT
    } scan_state_t;

endpackage

// ==== source/cfg_capture_if.sv ====
// Capture path from the scan state machine to the field register bank.
// One decoded Device Control read per valid strobe, no back-pressure.

`timescale 1ns/1ps

interface cfg_capture_if;

    import pcie_cfg_pkg::*;

    // Single-cycle strobe
    logic      valid;
    // Function the fields belong to
    func_num_t func;
    dev_ctrl_t fields;
    // High with valid on the final function of a scan
    logic      last;

    modport fsm (
        output valid,
        output func,
        output fields,
        output last
    );

    modport regs (
        input valid,
        input func,
        input fields,
        input last
    );

endinterface

// ==== source/cfg_refresh_timer.sv ====
// Free-running interval timer for the configuration readback engine.
// Pulses scan_start for one clock every CFG_REFRESH_CYCLES clocks,
// the first one CFG_REFRESH_CYCLES clocks after reset release.

`timescale 1ns/1ps

`include "pcie_cfg_macros.svh"

module cfg_refresh_timer (
    input  logic clk,
    input  logic rst_n,
    output logic scan_start
);

    localparam int CNT_W = $clog2(`CFG_REFRESH_CYCLES);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`CFG_REFRESH_CYCLES - 1);

    logic [CNT_W-1:0] count;

    // Counts down to zero, then reloads and strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count      <= RELOAD;
            scan_start <= 1'b0;
        end else begin
            if (count == '0) begin
                count      <= RELOAD;
                scan_start <= 1'b1;
            end else begin
                count      <= count - 1'b1;
                scan_start <= 1'b0;
            end
        end
    end

endmodule

// ==== source/cfg_scan_fsm.sv ====
// Scan sequencer for the configuration management read port.
// On scan_start it reads Device Control of each physical function in turn,
// holds every read until the core signals done, then decodes the returned
// dword and strobes the fields onto the capture interface.

`timescale 1ns/1ps

`include "pcie_cfg_macros.svh"

module cfg_scan_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  scan_start,

    // Configuration management read port
    output pcie_cfg_pkg::cfg_addr_t cfg_mgmt_addr,
    output pcie_cfg_pkg::func_num_t cfg_mgmt_function_number,
    output logic                  cfg_mgmt_read,
    input  logic [31:0]           cfg_mgmt_read_data,
    input  logic                  cfg_mgmt_read_write_done,

    // Decoded fields towards the register bank
    cfg_capture_if.fsm            cap
);

    import pcie_cfg_pkg::*;

    localparam func_num_t LAST_FUNC = func_num_t'(`PCIE_PF_COUNT - 1);

    scan_state_t state;
    func_num_t   func_idx;
    logic        last_func;
    logic        cap_valid;
    dev_ctrl_t   cap_fields;

    // Pull the three fields out of a Device Control dword
    function automatic dev_ctrl_t decode_dev_ctrl(input logic [31:0] data);
        dev_ctrl_t f;
        f.ext_tag = data[`DEV_CTRL_EXT_TAG_BIT];
        f.mrrs    = data[`DEV_CTRL_MRRS_LSB +: 3];
        f.mps     = data[`DEV_CTRL_MPS_LSB +: 3];
        return f;
    endfunction

    assign last_func = (func_idx == LAST_FUNC);

    // Only Device Control is ever read
    assign cfg_mgmt_addr            = cfg_addr_t'(`PCIE_DEV_CTRL_DWORD);
    assign cfg_mgmt_function_number = func_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            func_idx      <= '0;
            cfg_mgmt_read <= 1'b0;
            cap_valid     <= 1'b0;
        end else begin
            cap_valid <= 1'b0;

            case (state)
                IDLE: begin
                    // A start during a running scan never reaches here
                    if (scan_start) begin
                        func_idx      <= '0;
                        cfg_mgmt_read <= 1'b1;
                        state         <= READ;
                    end
                end

                READ: begin
                    // Hold address, function and read until done
                    if (cfg_mgmt_read_write_done) begin
                        cfg_mgmt_read <= 1'b0;
                        cap_valid     <= 1'b1;
                        state         <= NEXT;
                    end
                end

                NEXT: begin
                    // Capture is on the interface this cycle
                    if (last_func) begin
                        state <= IDLE;
                    end else begin
                        func_idx      <= func_idx + 1'b1;
                        cfg_mgmt_read <= 1'b1;
                        state         <= READ;
                    end
                end

                default: begin
                    cfg_mgmt_read <= 1'b0;
                    state         <= IDLE;
                end
            endcase
        end
    end

    // Returned dword is only meaningful with done
    always_ff @(posedge clk) begin
        if (state == READ && cfg_mgmt_read_write_done) begin
            cap_fields <= decode_dev_ctrl(cfg_mgmt_read_data);
        end
    end

    // func_idx still points at the captured function while valid is high
    assign cap.valid  = cap_valid;
    assign cap.func   = func_idx;
    assign cap.fields = cap_fields;
    assign cap.last   = cap_valid & last_func;

endmodule

// ==== source/dev_ctrl_regs.sv ====
// Per-function store of the decoded Device Control fields.
// Written from the capture interface, read out as flat buses for the DMA
// logic with function 0 in the low bits.

`timescale 1ns/1ps

`include "pcie_cfg_macros.svh"

module dev_ctrl_regs (
    input  logic                          clk,
    input  logic                          rst_n,

    cfg_capture_if.regs                   cap,

    output logic [`PCIE_PF_COUNT-1:0]     ext_tag_enable,
    output logic [`PCIE_PF_COUNT*3-1:0]   max_read_request_size,
    output logic [`PCIE_PF_COUNT*3-1:0]   max_payload_size
);

    import pcie_cfg_pkg::*;

    dev_ctrl_t entry [`PCIE_PF_COUNT];

    genvar i;

    generate
        for (i = 0; i < `PCIE_PF_COUNT; i++) begin : g_func
            // One entry per function, updated when its capture arrives
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    entry[i] <= '0;
                end else if (cap.valid && cap.func == func_num_t'(i)) begin
                    entry[i] <= cap.fields;
                end
            end

            // Flatten onto the output buses
            assign ext_tag_enable[i]            = entry[i].ext_tag;
            assign max_read_request_size[i*3 +: 3] = entry[i].mrrs;
            assign max_payload_size[i*3 +: 3]      = entry[i].mps;
        end
    endgenerate

endmodule

// ==== source/pcie_cfg_reader.sv ====
// Configuration readback engine of the PCIe endpoint adapter.
// Periodically reads Device Control of every physical function over the
// core's configuration management port and presents extended tag enable,
// max read request size and max payload size to the DMA logic.

`timescale 1ns/1ps

`include "pcie_cfg_macros.svh"

module pcie_cfg_reader (
    input  logic                          clk,
    input  logic                          rst_n,

    // Configuration management port of the PCIe core
    output pcie_cfg_pkg::cfg_addr_t       cfg_mgmt_addr,
    output pcie_cfg_pkg::func_num_t       cfg_mgmt_function_number,
    output logic                          cfg_mgmt_read,
    input  logic [31:0]                   cfg_mgmt_read_data,
    input  logic                          cfg_mgmt_read_write_done,

    // Per-function settings for the DMA logic
    output logic [`PCIE_PF_COUNT-1:0]     ext_tag_enable,
    output logic [`PCIE_PF_COUNT*3-1:0]   max_read_request_size,
    output logic [`PCIE_PF_COUNT*3-1:0]   max_payload_size
);

    logic scan_start;

    cfg_capture_if cap_if ();

    // Scan interval
    cfg_refresh_timer cfg_refresh_timer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_start (scan_start)
    );

    // Walks the functions and decodes each read
    cfg_scan_fsm cfg_scan_fsm_i (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .scan_start               (scan_start),
        .cfg_mgmt_addr            (cfg_mgmt_addr),
        .cfg_mgmt_function_number (cfg_mgmt_function_number),
        .cfg_mgmt_read            (cfg_mgmt_read),
        .cfg_mgmt_read_data       (cfg_mgmt_read_data),
        .cfg_mgmt_read_write_done (cfg_mgmt_read_write_done),
        .cap                      (cap_if.fsm)
    );

    // Holds the fields per function
    dev_ctrl_regs dev_ctrl_regs_i (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cap                   (cap_if.regs),
        .ext_tag_enable        (ext_tag_enable),
        .max_read_request_size (max_read_request_size),
        .max_payload_size      (max_payload_size)
    );

endmodule

// ==== testbench/pcie_cfg_reader_asserts.sv ====
// Concurrent checks on the configuration management read handshake.
// Bound into the RTL top level; fail_count lets the testbench see failures.

`timescale 1ns/1ps

module pcie_cfg_reader_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input pcie_cfg_pkg::cfg_addr_t cfg_mgmt_addr,
    input pcie_cfg_pkg::func_num_t cfg_mgmt_function_number,
    input logic                    cfg_mgmt_read,
    input logic                    cfg_mgmt_read_write_done,
    input logic                    cap_valid,
    input logic                    cap_last
);

    int fail_count = 0;

    // Read held until the core answers
    read_held: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_mgmt_read && !cfg_mgmt_read_write_done |=> cfg_mgmt_read)
        else begin
            fail_count++;
            $error("cfg_mgmt_read dropped before done");
        end

    // Address and function frozen during a pending read
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_mgmt_read && !cfg_mgmt_read_write_done
        |=> $stable(cfg_mgmt_addr) && $stable(cfg_mgmt_function_number))
        else begin
            fail_count++;
            $error("Address or function number changed during a read");
        end

    // No read while in reset
    reset_idle: assert property (@(posedge clk) !rst_n |-> !cfg_mgmt_read)
        else begin
            fail_count++;
            $error("cfg_mgmt_read high during reset");
        end

    // Capture of an earlier function is followed by the next read
    scan_continues: assert property (@(posedge clk) disable iff (!rst_n)
        cap_valid && !cap_last |=> cfg_mgmt_read)
        else begin
            fail_count++;
            $error("No read issued after the capture of a function that is not the last");
        end

    // Scan ends with the capture of the last function
    scan_ends: assert property (@(posedge clk) disable iff (!rst_n)
        cap_last |=> !cfg_mgmt_read)
        else begin
            fail_count++;
            $error("Read issued after the capture of the last function");
        end

endmodule

bind pcie_cfg_reader pcie_cfg_reader_asserts pcie_cfg_reader_asserts_i (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .cfg_mgmt_addr            (cfg_mgmt_addr),
    .cfg_mgmt_function_number (cfg_mgmt_function_number),
    .cfg_mgmt_read            (cfg_mgmt_read),
    .cfg_mgmt_read_write_done (cfg_mgmt_read_write_done),
    .cap_valid                (cap_if.valid),
    .cap_last                 (cap_if.last)
);

// ==== testbench/tb_pcie_cfg_reader.sv ====
// Testbench for the configuration readback engine.
// Models the core's configuration space from the case file, answers each read
// after the listed delay and checks request order and the decoded outputs.

`timescale 1ns/1ps

`include "pcie_cfg_macros.svh"

module tb_pcie_cfg_reader;

    import pcie_cfg_pkg::*;

    localparam int MAX_CASES = 32;
    localparam int CASE_COLS = 7;
    localparam int RESET_CYCLES = 3;
    // Reset, one refresh interval to the first start, one cycle to the read
    localparam int FIRST_READ_CYCLE = RESET_CYCLES + `CFG_REFRESH_CYCLES + 1;
    // Device Control dword, 8 bytes past the capability at 0x0C0
    localparam cfg_addr_t DEV_CTRL_ADDR = 10'h032;

    logic                        clk;
    logic                        rst_n;
    cfg_addr_t                   cfg_mgmt_addr;
    func_num_t                   cfg_mgmt_function_number;
    logic                        cfg_mgmt_read;
    logic [31:0]                 cfg_mgmt_read_data;
    logic                        cfg_mgmt_read_write_done;
    logic [`PCIE_PF_COUNT-1:0]   ext_tag_enable;
    logic [`PCIE_PF_COUNT*3-1:0] max_read_request_size;
    logic [`PCIE_PF_COUNT*3-1:0] max_payload_size;

    // Word 0 is the case count, then CASE_COLS words per case
    logic [31:0] case_mem [0:MAX_CASES*CASE_COLS];

    int num_cases = 0;
    int num_rounds = 0;
    int timeout_limit = 0;
    int cycle_count = 0;
    int reads_seen = 0;
    int reads_done = 0;
    int mismatch_errors = 0;
    int other_errors = 0;
    int assert_errors = 0;

    dev_ctrl_t exp_fields [`PCIE_PF_COUNT];

    pcie_cfg_reader pcie_cfg_reader_i (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .cfg_mgmt_addr            (cfg_mgmt_addr),
        .cfg_mgmt_function_number (cfg_mgmt_function_number),
        .cfg_mgmt_read            (cfg_mgmt_read),
        .cfg_mgmt_read_data       (cfg_mgmt_read_data),
        .cfg_mgmt_read_write_done (cfg_mgmt_read_write_done),
        .ext_tag_enable           (ext_tag_enable),
        .max_read_request_size    (max_read_request_size),
        .max_payload_size         (max_payload_size)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Columns: round, function, value, delay, ext_tag, mrrs, mps
    function automatic int word_index(input int idx, input int col);
        return 1 + idx * CASE_COLS + col;
    endfunction

    function automatic int find_case(input int round, input int func);
        int i;
        for (i = 0; i < num_cases; i++) begin
            if (int'(case_mem[word_index(i, 0)]) == round &&
                int'(case_mem[word_index(i, 1)]) == func) begin
                return i;
            end
        end
        return -1;
    endfunction

    // One function's slice of the flat output buses
    function automatic dev_ctrl_t outputs_of(input int f);
        dev_ctrl_t d;
        d.ext_tag = ext_tag_enable[f];
        d.mrrs    = max_read_request_size[f*3 +: 3];
        d.mps     = max_payload_size[f*3 +: 3];
        return d;
    endfunction

    task automatic check_addr(input string name, input cfg_addr_t exp, input cfg_addr_t act);
        if (exp !== act) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_func(input string name, input func_num_t exp, input func_num_t act);
        if (exp !== act) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_fields(input string name, input dev_ctrl_t exp, input dev_ctrl_t act);
        if (exp !== act) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected ext_tag %0h mrrs %0h mps %0h, actual %0h %0h %0h",
                     name, exp.ext_tag, exp.mrrs, exp.mps, act.ext_tag, act.mrrs, act.mps);
        end
    endtask

    // Every function, so untouched entries are seen to hold
    task automatic check_outputs(input string name);
        int f;
        for (f = 0; f < `PCIE_PF_COUNT; f++) begin
            check_fields($sformatf("%s, function %0d", name, f), exp_fields[f], outputs_of(f));
        end
    endtask

    task automatic load_cases();
        int i;
        $readmemh("testbench/cfg_reader_cases.txt", case_mem);
        num_cases = int'(case_mem[0]);
        if (num_cases < 1 || num_cases > MAX_CASES) begin
            other_errors++;
            $display("Case file gives an unusable case count of %0d", num_cases);
            num_cases = 0;
        end
        for (i = 0; i < num_cases; i++) begin
            if (int'(case_mem[word_index(i, 0)]) + 1 > num_rounds) begin
                num_rounds = int'(case_mem[word_index(i, 0)]) + 1;
            end
        end
        timeout_limit = (num_rounds + 2) * `CFG_REFRESH_CYCLES + 100;
    endtask

    // Answers the read seen at this falling edge, then checks the outputs
    task automatic serve_read();
        int        idx;
        int        delay;
        int        w;
        int        f;
        int        round;
        dev_ctrl_t fields;
        f     = reads_seen % `PCIE_PF_COUNT;
        round = reads_seen / `PCIE_PF_COUNT;
        check_addr($sformatf("round %0d read %0d address", round, f),
                   DEV_CTRL_ADDR, cfg_mgmt_addr);
        check_func($sformatf("round %0d read %0d function", round, f),
                   func_num_t'(f), cfg_mgmt_function_number);
        reads_seen++;
        idx = find_case(round, f);
        fields = '0;
        if (idx < 0) begin
            other_errors++;
            $display("No case line for round %0d function %0d", round, f);
            delay = 1;
            cfg_mgmt_read_data = 32'h0;
        end else begin
            delay = int'(case_mem[word_index(idx, 3)]);
            if (delay == 0) begin
                delay = int'($urandom_range(8, 1));
            end
            cfg_mgmt_read_data = case_mem[word_index(idx, 2)];
            fields.ext_tag = case_mem[word_index(idx, 4)][0];
            fields.mrrs    = case_mem[word_index(idx, 5)][2:0];
            fields.mps     = case_mem[word_index(idx, 6)][2:0];
        end
        for (w = 1; w < delay; w++) begin
            @(negedge clk);
            if (!cfg_mgmt_read) begin
                other_errors++;
                $display("Read of function %0d dropped before done in round %0d", f, round);
            end
        end
        cfg_mgmt_read_write_done = 1'b1;
        @(negedge clk);
        cfg_mgmt_read_write_done = 1'b0;
        cfg_mgmt_read_data = 32'h0;
        if (cfg_mgmt_read) begin
            other_errors++;
            $display("Read of function %0d still high in the cycle after done", f);
        end
        // Outputs settle two cycles after done
        @(negedge clk);
        if (idx >= 0) begin
            exp_fields[f] = fields;
        end
        check_outputs($sformatf("round %0d after read of function %0d", round, f));
        reads_done++;
    endtask

    task automatic print_counts();
        assert_errors = pcie_cfg_reader_i.pcie_cfg_reader_asserts_i.fail_count;
        $display("Errors: %0d mismatch, %0d protocol, %0d assertion",
                 mismatch_errors, other_errors, assert_errors);
    endtask

    // Core model, also watches the idle state before the first scan
    initial begin : responder
        void'($urandom(54950));
        forever begin
            @(negedge clk);
            if (rst_n && cfg_mgmt_read) begin
                if (reads_seen == 0 && cycle_count != FIRST_READ_CYCLE) begin
                    other_errors++;
                    $display("First read raised in cycle %0d instead of cycle %0d",
                             cycle_count, FIRST_READ_CYCLE);
                end
                serve_read();
            end else if (reads_seen == 0) begin
                if (cfg_mgmt_read) begin
                    other_errors++;
                    $display("Read raised during reset");
                end
                check_outputs("before first scan");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            other_errors++;
            $display("Timeout after %0d cycles with %0d of %0d reads done",
                     cycle_count, reads_done, num_cases);
            print_counts();
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int f;
        rst_n = 1'b0;
        cfg_mgmt_read_data = 32'h0;
        cfg_mgmt_read_write_done = 1'b0;
        for (f = 0; f < `PCIE_PF_COUNT; f++) begin
            exp_fields[f] = '0;
        end
        load_cases();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (reads_done < num_cases) begin
            @(negedge clk);
        end
        @(negedge clk);
        print_counts();
        if (mismatch_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+source
source/pcie_cfg_pkg.sv
source/cfg_capture_if.sv
source/cfg_refresh_timer.sv
source/cfg_scan_fsm.sv
source/dev_ctrl_regs.sv
source/pcie_cfg_reader.sv
testbench/pcie_cfg_reader_asserts.sv
testbench/tb_pcie_cfg_reader.sv

// ==== Makefile ====
# Verilator build and run of the configuration readback engine testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pcie_cfg_reader \
		-f tb.f -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "TEST FAILED: no result in $(LOG)"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/cfg_reader_cases.txt ====
// round func devctrl_value done_delay ext_tag mrrs mps, all hex
// First value is the number of case lines, done_delay 0 means random 1 to 8
8
0 0 00002930 1 1 2 1
0 1 FFFF0850 3 0 0 2
1 0 12345BE0 8 1 5 7
1 1 000040A0 0 0 4 5
2 0 A5A50000 5 0 0 0
2 1 00007FFF 0 1 7 7
3 0 00003120 0 1 3 1
3 1 FFFF8E1F 2 0 0 0
